// File: compile.f
+incdir+include
rtl/cpuPkg.sv
rtl/stageReg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/regFile.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/cpuTop.sv
bench/cpuTb.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - rtl/cpuPkg.sv
  - rtl/stageReg.sv
  - rtl/fetchStage.sv
  - rtl/decodeStage.sv
  - rtl/regFile.sv
  - rtl/executeStage.sv
  - rtl/memoryStage.sv
  - rtl/cpuTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/cpuTb.sv

// File: include/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Program words from startPc and the expected output sequences
wordT prog[$];
logic [hexBits-1:0] expHex[$];
logic [ledrBits-1:0] expLedr[$];

function automatic wordT aluModel(input op2T f, input wordT a, input wordT b);
	case (f)
		op2Eq: return (a == b) ? 32'd1 : 32'd0;
		op2Lt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		op2Le: return ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
		op2Ne: return (a != b) ? 32'd1 : 32'd0;
		op2Add: return a + b;
		op2And: return a & b;
		op2Or: return a | b;
		op2Xor: return a ^ b;
		op2Sub: return a - b;
		op2Nand: return ~(a & b);
		op2Nor: return ~(a | b);
		op2Nxor: return ~(a ^ b);
		op2Rshf: return wordT'($signed(a) >>> b);
		op2Lshf: return a << b;
		default: return 32'd0;
	endcase
endfunction

// Runs the program one instruction at a time until the closing self jump
task automatic runModel();
	wordT r [16];
	wordT dmem [int];
	wordT pc;
	wordT inst;
	wordT imm;
	wordT addr;
	wordT next;
	logic [hexBits-1:0] lastHex;
	logic [ledrBits-1:0] lastLedr;
	logic taken;
	logic done;
	int steps;
	op1T op1;
	regNoT rs;
	regNoT rt;
	expHex.delete();
	expLedr.delete();
	foreach (r[i]) r[i] = '0;
	pc = startPc;
	lastHex = hexResetVal;
	lastLedr = ledrResetVal;
	done = 1'b0;
	steps = 0;
	while (!done && steps < 5000) begin
		inst = prog[(pc - startPc) >> 2];
		op1 = inst[31:26];
		rs = inst[7:4];
		rt = inst[3:0];
		imm = {{16{inst[23]}}, inst[23:8]};
		addr = r[rs] + imm;
		next = pc + 4;
		case (op1)
			op1Alur: r[inst[11:8]] = aluModel(inst[25:18], r[rs], r[rt]);
			op1Addi: r[rt] = r[rs] + imm;
			op1Andi: r[rt] = r[rs] & imm;
			op1Ori: r[rt] = r[rs] | imm;
			op1Xori: r[rt] = r[rs] ^ imm;
			op1Beq, op1Blt, op1Ble, op1Bne: begin
				case (op1)
					op1Beq: taken = (r[rs] == r[rt]);
					op1Blt: taken = ($signed(r[rs]) < $signed(r[rt]));
					op1Ble: taken = ($signed(r[rs]) <= $signed(r[rt]));
					default: taken = (r[rs] != r[rt]);
				endcase
				if (taken) next = pc + 4 + (imm << 2);
			end
			op1Jal: begin
				// Target is taken before the link overwrites rt
				next = r[rs] + (imm << 2);
				r[rt] = pc + 4;
				done = (next == pc);
			end
			op1Lw: begin
				if (addr < 32'h10000)
					r[rt] = dmem.exists(addr[15:2]) ? dmem[addr[15:2]] : 'x;
				else
					r[rt] = unmappedWord;
			end
			op1Sw: begin
				if (addr < 32'h10000) begin
					dmem[addr[15:2]] = r[rt];
				end else if (addr == addrHex && r[rt][hexBits-1:0] != lastHex) begin
					lastHex = r[rt][hexBits-1:0];
					expHex.push_back(lastHex);
				end else if (addr == addrLedr && r[rt][ledrBits-1:0] != lastLedr) begin
					lastLedr = r[rt][ledrBits-1:0];
					expLedr.push_back(lastLedr);
				end
			end
			default: ;
		endcase
		pc = next;
		steps++;
	end
endtask

`endif

// File: bench/cpuTb.sv
`timescale 1ns/1ns

module cpuTb;
	import cpuPkg::*;

	logic clk;
	logic reset;
	logic imemWrite;
	wordT imemAddr;
	wordT imemData;
	logic [hexBits-1:0] hexOut;
	logic [ledrBits-1:0] ledr;

	logic [15:0] lfsrState;
	int errors;
	int passed;
	int failed;

	`include "isaModel.svh"

	cpuTop uut (
		.clk(clk),
		.reset(reset),
		.imemWrite(imemWrite),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.hexOut(hexOut),
		.ledr(ledr)
	);

	always #4 clk = ~clk;

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic wordT takeBits(input int n);
		wordT v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	function automatic wordT encR(input op2T f, input int rd, input int rs, input int rt);
		return {op1Alur, f, 6'b0, 4'(rd), 4'(rs), 4'(rt)};
	endfunction

	function automatic wordT encI(input op1T op, input wordT imm, input int rs, input int rt);
		return {op, 2'b00, imm[15:0], 4'(rs), 4'(rt)};
	endfunction

	function automatic op2T funcAt(input int i);
		case (i)
			0: return op2Eq;
			1: return op2Lt;
			2: return op2Le;
			3: return op2Ne;
			4: return op2Add;
			5: return op2And;
			6: return op2Or;
			7: return op2Xor;
			8: return op2Sub;
			9: return op2Nand;
			10: return op2Nor;
			11: return op2Nxor;
			12: return op2Rshf;
			default: return op2Lshf;
		endcase
	endfunction

	function automatic op1T immOpAt(input int i);
		case (i)
			0: return op1Addi;
			1: return op1Andi;
			2: return op1Ori;
			default: return op1Xori;
		endcase
	endfunction

	function automatic op1T branchAt(input int i);
		case (i)
			0: return op1Beq;
			1: return op1Blt;
			2: return op1Ble;
			default: return op1Bne;
		endcase
	endfunction

	// r0 stays zero and serves as the base of every absolute address
	function automatic int destReg();
		return 1 + int'(takeBits(4)) % 13;
	endfunction

	function automatic int srcReg();
		return int'(takeBits(4)) % 14;
	endfunction

	task automatic storeTo(input int rt, input wordT imm);
		prog.push_back(encI(op1Sw, imm, 0, rt));
	endtask

	// Closing jump to itself that links into r14
	task automatic endProgram();
		wordT here;
		here = startPc + 4 * prog.size();
		prog.push_back(encI(op1Jal, here >> 2, 0, 14));
	endtask

	task automatic buildChain();
		int prev;
		int rd;
		prog.delete();
		prog.push_back(encI(op1Addi, takeBits(16), 0, 1));
		prog.push_back(encI(op1Addi, 1 + takeBits(4), 0, 2));
		prev = 1;
		for (int i = 0; i < 18; i++) begin
			rd = (i % 2 == 0) ? 3 : 4;
			if (i < 14)
				prog.push_back(encR(funcAt(i), rd, prev, 2));
			else
				prog.push_back(encI(immOpAt(i - 14), takeBits(16), prev, rd));
			storeTo(rd, 16'hF000);
			prev = rd;
		end
		endProgram();
	endtask

	task automatic buildMemory();
		prog.delete();
		prog.push_back(encI(op1Addi, takeBits(16), 0, 1));
		prog.push_back(encI(op1Addi, takeBits(16), 0, 2));
		storeTo(1, 16'h0040);
		storeTo(2, 16'h0044);
		prog.push_back(encI(op1Lw, 16'h0040, 0, 3));
		prog.push_back(encI(op1Lw, 16'h0044, 0, 4));
		storeTo(3, 16'hF020);
		storeTo(4, 16'hF020);
		prog.push_back(encI(op1Lw, 16'h8000, 0, 5));
		storeTo(5, 16'hF020);
		endProgram();
	endtask

	// Each case skips two display stores when taken
	task automatic buildBranches();
		int n;
		prog.delete();
		prog.push_back(encI(op1Addi, takeBits(16), 0, 1));
		prog.push_back(encI(op1Addi, takeBits(16), 0, 2));
		n = 0;
		for (int k = 0; k < 4; k++) begin
			for (int p = 0; p < 3; p++) begin
				prog.push_back(encI(op1Addi, 4 * n + 1, 0, 3));
				prog.push_back(encI(op1Addi, 4 * n + 2, 0, 4));
				prog.push_back(encI(op1Addi, 4 * n + 3, 0, 5));
				prog.push_back(encI(branchAt(k), 2, (p == 2) ? 2 : 1, (p == 0) ? 1 : 2));
				storeTo(3, 16'hF000);
				storeTo(4, 16'hF000);
				storeTo(5, 16'hF000);
				n++;
			end
		end
		endProgram();
	endtask

	task automatic buildJumps();
		prog.delete();
		prog.push_back(encI(op1Addi, startPc + 8, 0, 1));
		prog.push_back(encI(op1Jal, 2, 1, 7));
		storeTo(1, 16'hF000);
		storeTo(0, 16'hF000);
		storeTo(7, 16'hF000);
		prog.push_back(encI(op1Jal, (startPc + 28) >> 2, 0, 8));
		storeTo(1, 16'hF000);
		storeTo(8, 16'hF000);
		endProgram();
	endtask

	task automatic buildRandom(input int bodyLen);
		int endIdx;
		int rem;
		int offset;
		int kind;
		prog.delete();
		// Data words that loads may read start cleared
		for (int i = 0; i < 4; i++) storeTo(0, 4 * i);
		endIdx = prog.size() + bodyLen;
		for (int i = prog.size(); i < endIdx; i++) begin
			rem = endIdx - (i + 1);
			offset = int'(takeBits(2)) % (rem + 1);
			kind = int'(takeBits(3));
			case (kind)
				0: prog.push_back(encR(funcAt(int'(takeBits(4)) % 14), destReg(), srcReg(),
					srcReg()));
				1: prog.push_back(encI(immOpAt(takeBits(2)), takeBits(16), srcReg(), destReg()));
				2: prog.push_back(encI(branchAt(takeBits(2)), offset, srcReg(), srcReg()));
				3: prog.push_back(encI(op1Jal, (startPc + 4 * (i + 1 + offset)) >> 2, 0,
					destReg()));
				4: prog.push_back(encI(op1Lw, takeBits(1) ? 16'h8000 : 4 * takeBits(2), 0,
					destReg()));
				5: storeTo(srcReg(), 4 * takeBits(2));
				6: storeTo(srcReg(), 16'hF000);
				default: storeTo(srcReg(), 16'hF020);
			endcase
		end
		endProgram();
	endtask

	task automatic checkHex(input logic [hexBits-1:0] expected, input logic [hexBits-1:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("FAILED hexOut expected %h got %h", expected, actual);
		end
	endtask

	task automatic checkLedr(input logic [ledrBits-1:0] expected,
		input logic [ledrBits-1:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("FAILED ledr expected %h got %h", expected, actual);
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		if (errors == errBefore) begin
			passed++;
			$display("%s: ok", name);
		end else begin
			failed++;
			$display("%s: %0d errors", name, errors - errBefore);
		end
	endtask

	task automatic checkReset();
		int errBefore;
		errBefore = errors;
		@(negedge clk);
		reset = 1'b1;
		for (int i = 0; i < 8; i++) @(negedge clk);
		checkHex(hexResetVal, hexOut);
		checkLedr(ledrResetVal, ledr);
		reportTest("reset values", errBefore);
	endtask

	// Loads the program under reset, then follows every output change
	task automatic runProgram(input string name);
		int errBefore;
		int cycles;
		int hexIdx;
		int ledrIdx;
		int idle;
		logic [hexBits-1:0] seenHex;
		logic [ledrBits-1:0] seenLedr;
		logic [hexBits-1:0] finalHex;
		logic [ledrBits-1:0] finalLedr;
		errBefore = errors;
		runModel();
		finalHex = hexResetVal;
		if (expHex.size() > 0) begin
			finalHex = expHex[expHex.size() - 1];
		end
		finalLedr = ledrResetVal;
		if (expLedr.size() > 0) begin
			finalLedr = expLedr[expLedr.size() - 1];
		end
		@(negedge clk);
		reset = 1'b1;
		cycles = 0;
		foreach (prog[i]) begin
			imemWrite = 1'b1;
			imemAddr = startPc + 4 * i;
			imemData = prog[i];
			@(negedge clk);
			cycles++;
		end
		imemWrite = 1'b0;
		while (cycles < 8) begin
			@(negedge clk);
			cycles++;
		end
		reset = 1'b0;
		seenHex = hexResetVal;
		seenLedr = ledrResetVal;
		hexIdx = 0;
		ledrIdx = 0;
		idle = 0;
		while (idle < 400 && (hexIdx < expHex.size() || ledrIdx < expLedr.size())) begin
			@(negedge clk);
			idle++;
			if (hexOut !== seenHex) begin
				seenHex = hexOut;
				if (hexIdx < expHex.size()) begin
					checkHex(expHex[hexIdx], hexOut);
					hexIdx++;
					idle = 0;
				end else begin
					errors++;
					$display("%s: display changed more often than expected", name);
				end
			end
			if (ledr !== seenLedr) begin
				seenLedr = ledr;
				if (ledrIdx < expLedr.size()) begin
					checkLedr(expLedr[ledrIdx], ledr);
					ledrIdx++;
					idle = 0;
				end else begin
					errors++;
					$display("%s: LEDs changed more often than expected", name);
				end
			end
		end
		if (hexIdx < expHex.size() || ledrIdx < expLedr.size()) begin
			errors++;
			$display("%s: timed out waiting for the display or LED outputs", name);
		end
		// The program spins on its last jump and the outputs keep their final values
		for (int i = 0; i < 40; i++) begin
			@(negedge clk);
			checkHex(finalHex, hexOut);
			checkLedr(finalLedr, ledr);
		end
		reportTest(name, errBefore);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		imemWrite = 1'b0;
		imemAddr = '0;
		imemData = '0;
		lfsrState = 16'd25;
		errors = 0;
		passed = 0;
		failed = 0;
		checkReset();
		buildChain();
		runProgram("ALU chain");
		buildMemory();
		runProgram("loads and stores");
		buildBranches();
		runProgram("branches");
		buildJumps();
		runProgram("jumps");
		for (int t = 0; t < 10; t++) begin
			buildRandom(30);
			runProgram($sformatf("random program %0d", t));
		end
		$display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: rtl/cpuTop.sv
`timescale 1ns/1ns

module cpuTop (
	input logic clk,
	input logic reset,
	input logic imemWrite,
	input cpuPkg::wordT imemAddr,
	input cpuPkg::wordT imemData,
	output logic [cpuPkg::hexBits-1:0] hexOut,
	output logic [cpuPkg::ledrBits-1:0] ledr
);
	import cpuPkg::*;

	fetchLatchT fetchIn;
	fetchLatchT fetchQ;
	decodeLatchT decodeIn;
	decodeLatchT decodeQ;
	execLatchT execIn;
	execLatchT execQ;
	wbT wbIn;
	wbT wbQ;
	redirectT redirect;
	logic stall;
	logic controlPending;
	logic execControl;
	logic holdF;
	logic bubbleF;
	logic bubbleD;
	logic issue;
	regNoT issueNo;
	regNoT readNo1;
	regNoT readNo2;
	wordT readVal1;
	wordT readVal2;
	logic busy1;
	logic busy2;
	logic busyDest;

	fetchStage fetch (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.controlPending(controlPending),
		.redirect(redirect),
		.imemWrite(imemWrite),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.fetched(fetchIn),
		.hold(holdF),
		.bubble(bubbleF)
	);

	stageReg #(.payloadT(fetchLatchT)) latchF (
		.clk(clk),
		.reset(reset),
		.hold(holdF),
		.bubble(bubbleF),
		.d(fetchIn),
		.q(fetchQ)
	);

	decodeStage decode (
		.fetched(fetchQ),
		.execControl(execControl),
		.readNo1(readNo1),
		.readNo2(readNo2),
		.readVal1(readVal1),
		.readVal2(readVal2),
		.busy1(busy1),
		.busy2(busy2),
		.busyDest(busyDest),
		.issue(issue),
		.issueNo(issueNo),
		.decoded(decodeIn),
		.stall(stall),
		.controlPending(controlPending),
		.bubble(bubbleD)
	);

	// Destination check and issue both use the decoded destination
	regFile regs (
		.clk(clk),
		.reset(reset),
		.readNo1(readNo1),
		.readNo2(readNo2),
		.readVal1(readVal1),
		.readVal2(readVal2),
		.destNo(issueNo),
		.busy1(busy1),
		.busy2(busy2),
		.busyDest(busyDest),
		.issue(issue),
		.issueNo(issueNo),
		.wb(wbQ)
	);

	stageReg #(.payloadT(decodeLatchT)) latchD (
		.clk(clk),
		.reset(reset),
		.hold(1'b0),
		.bubble(bubbleD),
		.d(decodeIn),
		.q(decodeQ)
	);

	executeStage execute (
		.decoded(decodeQ),
		.executed(execIn),
		.redirect(redirect),
		.execControl(execControl)
	);

	stageReg #(.payloadT(execLatchT)) latchE (
		.clk(clk),
		.reset(reset),
		.hold(1'b0),
		.bubble(1'b0),
		.d(execIn),
		.q(execQ)
	);

	memoryStage memory (
		.clk(clk),
		.reset(reset),
		.executed(execQ),
		.wb(wbIn),
		.hexOut(hexOut),
		.ledr(ledr)
	);

	stageReg #(.payloadT(wbT)) latchM (
		.clk(clk),
		.reset(reset),
		.hold(1'b0),
		.bubble(1'b0),
		.d(wbIn),
		.q(wbQ)
	);

endmodule

// File: rtl/memoryStage.sv
`timescale 1ns/1ns

module memoryStage (
	input logic clk,
	input logic reset,
	input cpuPkg::execLatchT executed,
	output cpuPkg::wbT wb,
	output logic [cpuPkg::hexBits-1:0] hexOut,
	output logic [cpuPkg::ledrBits-1:0] ledr
);
	import cpuPkg::*;

	wordT dmem [memWords];
	wordT addr;
	wordT memOut;
	logic inDmem;
	logic doStore;

	assign addr = executed.aluOut;
	// Data memory sits below 0x10000
	assign inDmem = (addr[dataBits-1:memAddrBits] == '0);
	assign doStore = executed.valid && executed.wrMem;

	always_ff @(posedge clk) begin
		if (doStore && inDmem) begin
			dmem[addr[memAddrBits-1:2]] <= executed.storeVal;
		end
	end

	// Memory-mapped display and LED registers
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hexOut <= hexResetVal;
			ledr <= ledrResetVal;
		end else if (doStore) begin
			if (addr == addrHex) begin
				hexOut <= executed.storeVal[hexBits-1:0];
			end
			if (addr == addrLedr) begin
				ledr <= executed.storeVal[ledrBits-1:0];
			end
		end
	end

	assign memOut = inDmem ? dmem[addr[memAddrBits-1:2]] : unmappedWord;

	always_comb begin
		wb.valid = executed.valid && executed.wrReg;
		wb.regNo = executed.destNo;
		case (executed.resSel)
			resMem: wb.value = memOut;
			resPc: wb.value = executed.pcPlus;
			default: wb.value = executed.aluOut;
		endcase
	end

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/1ns

module executeStage (
	input cpuPkg::decodeLatchT decoded,
	output cpuPkg::execLatchT executed,
	output cpuPkg::redirectT redirect,
	output logic execControl
);
	import cpuPkg::*;

	logic signed [dataBits-1:0] aluIn1;
	logic signed [dataBits-1:0] aluIn2;
	wordT aluOut;
	wordT immWords;
	wordT brTarget;
	wordT jmpTarget;
	logic taken;
	logic isControl;

	assign aluIn1 = decoded.regVal1;
	assign aluIn2 = decoded.ctrl.aluImm ? decoded.imm : decoded.regVal2;

	// Signed ALU where compares give 0 or 1
	always_comb begin
		case (decoded.ctrl.aluFunc)
			op2Eq: aluOut = wordT'(aluIn1 == aluIn2);
			op2Lt: aluOut = wordT'(aluIn1 < aluIn2);
			op2Le: aluOut = wordT'(aluIn1 <= aluIn2);
			op2Ne: aluOut = wordT'(aluIn1 != aluIn2);
			op2Add: aluOut = aluIn1 + aluIn2;
			op2And: aluOut = aluIn1 & aluIn2;
			op2Or: aluOut = aluIn1 | aluIn2;
			op2Xor: aluOut = aluIn1 ^ aluIn2;
			op2Sub: aluOut = aluIn1 - aluIn2;
			op2Nand: aluOut = ~(aluIn1 & aluIn2);
			op2Nor: aluOut = ~(aluIn1 | aluIn2);
			op2Nxor: aluOut = ~(aluIn1 ^ aluIn2);
			op2Rshf: aluOut = aluIn1 >>> aluIn2;
			op2Lshf: aluOut = aluIn1 << aluIn2;
			default: aluOut = '0;
		endcase
	end

	// Offsets count words
	assign immWords = decoded.imm << 2;
	assign brTarget = decoded.pcPlus + immWords;
	assign jmpTarget = decoded.regVal1 + immWords;
	assign taken = decoded.ctrl.isBranch && aluOut[0];
	assign isControl = decoded.valid && (decoded.ctrl.isBranch || decoded.ctrl.isJump);

	always_comb begin
		redirect.valid = isControl;
		if (taken) begin
			redirect.nextPc = brTarget;
		end else if (decoded.ctrl.isJump) begin
			redirect.nextPc = jmpTarget;
		end else begin
			redirect.nextPc = decoded.pcPlus;
		end
	end

	assign execControl = isControl;

	always_comb begin
		executed.valid = decoded.valid;
		executed.wrMem = decoded.ctrl.wrMem;
		executed.wrReg = decoded.ctrl.wrReg;
		executed.destNo = decoded.ctrl.destNo;
		executed.resSel = decoded.ctrl.resSel;
		executed.aluOut = aluOut;
		executed.storeVal = decoded.regVal2;
		executed.pcPlus = decoded.pcPlus;
	end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/1ns

module regFile (
	input logic clk,
	input logic reset,
	input cpuPkg::regNoT readNo1,
	input cpuPkg::regNoT readNo2,
	output cpuPkg::wordT readVal1,
	output cpuPkg::wordT readVal2,
	input cpuPkg::regNoT destNo,
	output logic busy1,
	output logic busy2,
	output logic busyDest,
	input logic issue,
	input cpuPkg::regNoT issueNo,
	input cpuPkg::wbT wb
);
	import cpuPkg::*;

	wordT regs [regWords];
	logic [regWords-1:0] busy;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (wb.valid) begin
			regs[wb.regNo] <= wb.value;
		end
	end

	// Writeback clears a busy bit before a new issue sets it again
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= '0;
		end else begin
			if (wb.valid) begin
				busy[wb.regNo] <= 1'b0;
			end
			if (issue) begin
				busy[issueNo] <= 1'b1;
			end
		end
	end

	assign readVal1 = regs[readNo1];
	assign readVal2 = regs[readNo2];
	assign busy1 = busy[readNo1];
	assign busy2 = busy[readNo2];
	assign busyDest = busy[destNo];

endmodule

// File: rtl/decodeStage.sv
`timescale 1ns/1ns

module decodeStage (
	input cpuPkg::fetchLatchT fetched,
	input logic execControl,
	output cpuPkg::regNoT readNo1,
	output cpuPkg::regNoT readNo2,
	input cpuPkg::wordT readVal1,
	input cpuPkg::wordT readVal2,
	input logic busy1,
	input logic busy2,
	input logic busyDest,
	output logic issue,
	output cpuPkg::regNoT issueNo,
	output cpuPkg::decodeLatchT decoded,
	output logic stall,
	output logic controlPending,
	output logic bubble
);
	import cpuPkg::*;

	op1T op1;
	op2T op2;
	regNoT rd;
	regNoT rs;
	regNoT rt;
	logic [immBits-1:0] rawImm;
	ctrlT ctrl;
	logic needRt;
	logic hazard;

	assign op1 = fetched.inst[31:26];
	assign op2 = fetched.inst[25:18];
	assign rawImm = fetched.inst[23:8];
	assign rd = fetched.inst[11:8];
	assign rs = fetched.inst[7:4];
	assign rt = fetched.inst[3:0];

	always_comb begin
		ctrl = '0;
		ctrl.aluFunc = op2Add;
		ctrl.resSel = resAlu;
		ctrl.destNo = rt;
		needRt = 1'b0;
		case (op1)
			op1Alur: begin
				ctrl.aluFunc = op2;
				ctrl.wrReg = 1'b1;
				ctrl.destNo = rd;
				needRt = 1'b1;
			end
			op1Beq, op1Blt, op1Ble, op1Bne: begin
				ctrl.isBranch = 1'b1;
				needRt = 1'b1;
				case (op1)
					op1Beq: ctrl.aluFunc = op2Eq;
					op1Blt: ctrl.aluFunc = op2Lt;
					op1Ble: ctrl.aluFunc = op2Le;
					default: ctrl.aluFunc = op2Ne;
				endcase
			end
			op1Jal: begin
				// Link goes to rt, target comes from rs
				ctrl.isJump = 1'b1;
				ctrl.wrReg = 1'b1;
				ctrl.resSel = resPc;
			end
			op1Lw: begin
				ctrl.aluImm = 1'b1;
				ctrl.wrReg = 1'b1;
				ctrl.resSel = resMem;
			end
			op1Sw: begin
				ctrl.aluImm = 1'b1;
				ctrl.wrMem = 1'b1;
				needRt = 1'b1;
			end
			op1Addi, op1Andi, op1Ori, op1Xori: begin
				ctrl.aluImm = 1'b1;
				ctrl.wrReg = 1'b1;
				case (op1)
					op1Andi: ctrl.aluFunc = op2And;
					op1Ori: ctrl.aluFunc = op2Or;
					op1Xori: ctrl.aluFunc = op2Xor;
					default: ctrl.aluFunc = op2Add;
				endcase
			end
			default: ;
		endcase
	end

	assign readNo1 = rs;
	assign readNo2 = rt;

	// Wait for any source still in flight, and for a busy destination
	assign hazard = busy1 || (needRt && busy2) || (ctrl.wrReg && busyDest);
	assign stall = fetched.valid && hazard;
	assign bubble = stall;
	assign controlPending = (fetched.valid && (ctrl.isBranch || ctrl.isJump)) || execControl;

	assign issue = fetched.valid && ctrl.wrReg && !stall;
	assign issueNo = ctrl.destNo;

	always_comb begin
		decoded.valid = fetched.valid;
		decoded.ctrl = ctrl;
		decoded.regVal1 = readVal1;
		decoded.regVal2 = readVal2;
		decoded.imm = {{(dataBits - immBits){rawImm[immBits-1]}}, rawImm};
		decoded.pcPlus = fetched.pcPlus;
	end

endmodule

// File: rtl/fetchStage.sv
`timescale 1ns/1ns

module fetchStage (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic controlPending,
	input cpuPkg::redirectT redirect,
	input logic imemWrite,
	input cpuPkg::wordT imemAddr,
	input cpuPkg::wordT imemData,
	output cpuPkg::fetchLatchT fetched,
	output logic hold,
	output logic bubble
);
	import cpuPkg::*;

	wordT pc;
	wordT pcPlus;
	wordT imem [memWords];

	assign pcPlus = pc + 32'd4;

	// Redirect from execute beats any hold
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= startPc;
		end else if (redirect.valid) begin
			pc <= redirect.nextPc;
		end else if (!(stall || controlPending)) begin
			pc <= pcPlus;
		end
	end

	// Byte-addressed program load port
	always_ff @(posedge clk) begin
		if (imemWrite) begin
			imem[imemAddr[memAddrBits-1:2]] <= imemData;
		end
	end

	always_comb begin
		fetched.valid = 1'b1;
		fetched.inst = imem[pc[memAddrBits-1:2]];
		fetched.pcPlus = pcPlus;
	end

	// A stalled decode must keep its instruction, even a pending branch
	assign hold = stall;
	assign bubble = controlPending && !stall;

endmodule

// File: rtl/stageReg.sv
`timescale 1ns/1ns

module stageReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic reset,
	input logic hold,
	input logic bubble,
	input payloadT d,
	output payloadT q
);

	// A cleared payload has its valid bit low and travels as a bubble
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			q <= '0;
		end else if (bubble) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

// File: rtl/cpuPkg.sv
package cpuPkg;

	localparam int dataBits = 32;
	localparam int regNoBits = 4;
	localparam int regWords = 1 << regNoBits;
	localparam int immBits = 16;
	localparam int memAddrBits = 16;
	// One word per four bytes of decoded address space
	localparam int memWords = 1 << (memAddrBits - 2);
	localparam int hexBits = 24;
	localparam int ledrBits = 10;

	typedef logic [dataBits-1:0] wordT;
	typedef logic [regNoBits-1:0] regNoT;
	typedef logic [5:0] op1T;
	typedef logic [7:0] op2T;

	// Primary opcodes
	localparam op1T op1Alur = 6'b000000;
	localparam op1T op1Beq = 6'b001000;
	localparam op1T op1Blt = 6'b001001;
	localparam op1T op1Ble = 6'b001010;
	localparam op1T op1Bne = 6'b001011;
	localparam op1T op1Jal = 6'b001100;
	localparam op1T op1Lw = 6'b010010;
	localparam op1T op1Sw = 6'b011010;
	localparam op1T op1Addi = 6'b100000;
	localparam op1T op1Andi = 6'b100100;
	localparam op1T op1Ori = 6'b100101;
	localparam op1T op1Xori = 6'b100110;

	// ALU functions
	localparam op2T op2Eq = 8'b00001000;
	localparam op2T op2Lt = 8'b00001001;
	localparam op2T op2Le = 8'b00001010;
	localparam op2T op2Ne = 8'b00001011;
	localparam op2T op2Add = 8'b00100000;
	localparam op2T op2And = 8'b00100100;
	localparam op2T op2Or = 8'b00100101;
	localparam op2T op2Xor = 8'b00100110;
	localparam op2T op2Sub = 8'b00101000;
	localparam op2T op2Nand = 8'b00101100;
	localparam op2T op2Nor = 8'b00101101;
	localparam op2T op2Nxor = 8'b00101110;
	localparam op2T op2Rshf = 8'b00110000;
	localparam op2T op2Lshf = 8'b00110001;

	localparam wordT startPc = 32'h00000100;
	localparam wordT addrHex = 32'hFFFFF000;
	localparam wordT addrLedr = 32'hFFFFF020;
	localparam wordT unmappedWord = 32'hDEADDEAD;
	localparam logic [hexBits-1:0] hexResetVal = 24'hFEDEAD;
	localparam logic [ledrBits-1:0] ledrResetVal = 10'h2AA;

	// Source of the value written back to the register file
	typedef enum logic [1:0] {resAlu, resMem, resPc} resSelT;

	typedef struct packed {
		logic aluImm;
		op2T aluFunc;
		logic isBranch;
		logic isJump;
		logic wrMem;
		logic wrReg;
		regNoT destNo;
		resSelT resSel;
	} ctrlT;

	typedef struct packed {
		logic valid;
		wordT inst;
		wordT pcPlus;
	} fetchLatchT;

	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		wordT regVal1;
		wordT regVal2;
		wordT imm;
		wordT pcPlus;
	} decodeLatchT;

	typedef struct packed {
		logic valid;
		logic wrMem;
		logic wrReg;
		regNoT destNo;
		resSelT resSel;
		wordT aluOut;
		wordT storeVal;
		wordT pcPlus;
	} execLatchT;

	// valid doubles as the register write enable
	typedef struct packed {
		logic valid;
		regNoT regNo;
		wordT value;
	} wbT;

	typedef struct packed {
		logic valid;
		wordT nextPc;
	} redirectT;

endpackage
